//--- logic/led_panel_defines.svh
/* panel geometry and fetch wait, kept small for simulation
   columns and half rows must be powers of two, FETCH_WAIT must fit in 2 bits */
`ifndef LED_PANEL_DEFINES_SVH
`define LED_PANEL_DEFINES_SVH

// columns shifted per row
`define PANEL_COLUMNS 8

// rows per half, top and bottom halves scan together
`define PANEL_HALF_ROWS 4

// bits of one pixel in one half
`define SUBPANEL_BITS 8

// timer load for one RAM fetch
// RAM read enable stays high this many cycles
`define FETCH_WAIT 3

`endif

//--- logic/panel_geometry_pkg.sv
/* address and pixel types, widths follow the panel defines
   RAM word layout matches pixel_pair_t, bottom half in the upper byte */
`default_nettype none

`include "led_panel_defines.svh"

package panel_geometry_pkg;

    // column index within a row
    typedef logic [$clog2(`PANEL_COLUMNS)-1:0] column_addr_t;

    // half-row index, shared by top and bottom
    typedef logic [$clog2(`PANEL_HALF_ROWS)-1:0] row_addr_t;

    // row in the upper bits, column below
    typedef logic [$bits(row_addr_t)+$bits(column_addr_t)-1:0] ram_addr_t;

    typedef logic [`SUBPANEL_BITS-1:0] subpixel_t;

    // one column of both halves
    typedef struct packed {
        subpixel_t bottom;
        subpixel_t top;
    } pixel_pair_t;

endpackage

`default_nettype wire

//--- logic/panel_ctrl_pkg.sv
/* scan FSM states, config selectors and the config / panel output bundles
   needs panel_geometry_pkg compiled first */
`default_nettype none

package panel_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        SHIFT,
        LATCH
    } scan_state_e;

    // config register selector
    typedef enum logic {
        CFG_RUN      = 1'b0,
        CFG_LAST_COL = 1'b1
    } cfg_reg_e;

    typedef struct packed {
        logic                               run;
        panel_geometry_pkg::column_addr_t   last_column;
    } panel_cfg_t;

    // levels and strobes towards the panel
    typedef struct packed {
        logic                               panel_clk;
        logic                               latch;
        logic                               blank;
        panel_geometry_pkg::row_addr_t      row;
        panel_geometry_pkg::pixel_pair_t    pixels;
    } panel_out_t;

endpackage

`default_nettype wire

//--- logic/timeout.sv
/* loadable down-counter, running while nonzero
   start wins over counting, a start with value 0 just stops it */
`default_nettype none
`timescale 1ns/1ps

module timeout #(
    parameter int counter_width = 2
) (
    input  wire logic                     reset,
    input  wire logic                     clk_in,
    input  wire logic                     start,
    input  wire logic [counter_width-1:0] value,
    output logic      [counter_width-1:0] counter,
    output logic                          running
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // reload, even mid count
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // high for exactly value cycles after the start cycle
    assign running = (counter != '0);

endmodule

`default_nettype wire

//--- logic/framebuffer_ram.sv
/* 32-word framebuffer, one write port and one enabled registered read port
   read data appears the cycle after read_enable, and holds while it is low */
`default_nettype none
`timescale 1ns/1ps

`include "led_panel_defines.svh"

module framebuffer_ram (
    input  wire logic                            reset,
    input  wire logic                            clk_in,
    input  wire logic                            write,
    input  wire panel_geometry_pkg::ram_addr_t   waddr,
    input  wire panel_geometry_pkg::pixel_pair_t wdata,
    input  wire logic                            read_enable,
    input  wire panel_geometry_pkg::ram_addr_t   raddr,
    output panel_geometry_pkg::pixel_pair_t      rdata
);

    // one word per column per half-row
    panel_geometry_pkg::pixel_pair_t mem [`PANEL_COLUMNS*`PANEL_HALF_ROWS];

    // host side
    always_ff @(posedge clk_in) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // fetch side, gated by the fetch timer
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rdata <= '0;
        end else if (read_enable) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- logic/framebuffer_fetch.sv
/* fetches one pixel pair per start pulse, pixels valid 3 cycles after start
   row and column must stay stable while ram_clk_enable is high */
`default_nettype none
`timescale 1ns/1ps

`include "led_panel_defines.svh"

module framebuffer_fetch (
    input  wire logic                             reset,
    input  wire logic                             clk_in,
    input  wire panel_geometry_pkg::column_addr_t column,
    input  wire panel_geometry_pkg::row_addr_t    row,
    input  wire logic                             pixel_load_start,
    input  wire panel_geometry_pkg::pixel_pair_t  ram_rdata,
    output panel_geometry_pkg::ram_addr_t         ram_address,
    output logic                                  ram_clk_enable,
    output panel_geometry_pkg::pixel_pair_t       pixels
);

    logic [1:0] pixel_load_counter;

    // row major, one row of columns is contiguous
    assign ram_address = {row, column};

    // counter runs 3, 2, 1 after the start cycle
    timeout #(
        .counter_width(2)
    ) fetch_timer (
        .reset   (reset),
        .clk_in  (clk_in),
        .start   (pixel_load_start),
        .value   (2'(`FETCH_WAIT)),
        .counter (pixel_load_counter),
        .running (ram_clk_enable)
    );

    // RAM word registered one cycle earlier, take it at count 2
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixels <= '0;
        end else if (pixel_load_counter == 2'd2) begin
            pixels <= ram_rdata;
        end
    end

endmodule

`default_nettype wire

//--- logic/panel_config_regs.sv
/* run bit and last active column, written by plain host strobes
   a new last column takes effect at the next end-of-column check */
`default_nettype none
`timescale 1ns/1ps

`include "led_panel_defines.svh"

module panel_config_regs (
    input  wire logic                     reset,
    input  wire logic                     clk_in,
    input  wire logic                     cfg_write,
    input  wire panel_ctrl_pkg::cfg_reg_e cfg_sel,
    input  wire logic [2:0]               cfg_wdata,
    output panel_ctrl_pkg::panel_cfg_t    cfg
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            // stopped, full width
            cfg.run         <= 1'b0;
            cfg.last_column <= panel_geometry_pkg::column_addr_t'(`PANEL_COLUMNS - 1);
        end else if (cfg_write) begin
            case (cfg_sel)
                panel_ctrl_pkg::CFG_RUN: begin
                    cfg.run <= cfg_wdata[0];
                end
                panel_ctrl_pkg::CFG_LAST_COL: begin
                    // low 3 bits hold the column
                    cfg.last_column <= cfg_wdata;
                end
                default: begin
                    cfg <= cfg;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/panel_scan.sv
/* column / row scan FSM, one fetch then one panel clock per column
   clearing run stops the scan only at the end of a frame */
`default_nettype none
`timescale 1ns/1ps

`include "led_panel_defines.svh"

module panel_scan (
    input  wire logic                            reset,
    input  wire logic                            clk_in,
    input  wire panel_ctrl_pkg::panel_cfg_t      cfg,
    input  wire logic                            ram_clk_enable,
    input  wire panel_geometry_pkg::pixel_pair_t pixels,
    output panel_geometry_pkg::column_addr_t     column,
    output panel_geometry_pkg::row_addr_t        row,
    output logic                                 pixel_load_start,
    output panel_ctrl_pkg::panel_out_t           panel_out,
    output logic                                 frame_done
);

    panel_ctrl_pkg::scan_state_e state;
    // read enable went high for the current fetch
    logic fetch_seen;
    logic last_row;

    assign last_row = (row == panel_geometry_pkg::row_addr_t'(`PANEL_HALF_ROWS - 1));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state               <= panel_ctrl_pkg::IDLE;
            column              <= '0;
            row                 <= '0;
            pixel_load_start    <= 1'b0;
            fetch_seen          <= 1'b0;
            frame_done          <= 1'b0;
            panel_out.panel_clk <= 1'b0;
            panel_out.latch     <= 1'b0;
            panel_out.blank     <= 1'b1;
            panel_out.row       <= '0;
            panel_out.pixels    <= '0;
        end else begin
            // strobes default low
            pixel_load_start <= 1'b0;
            frame_done       <= 1'b0;
            case (state)
                panel_ctrl_pkg::IDLE: begin
                    if (cfg.run) begin
                        state            <= panel_ctrl_pkg::FETCH;
                        pixel_load_start <= 1'b1;
                        panel_out.blank  <= 1'b0;
                    end
                end
                panel_ctrl_pkg::FETCH: begin
                    if (ram_clk_enable) begin
                        fetch_seen <= 1'b1;
                    end
                    // falling read enable means the pixels are captured
                    if (fetch_seen && !ram_clk_enable) begin
                        fetch_seen          <= 1'b0;
                        state               <= panel_ctrl_pkg::SHIFT;
                        panel_out.panel_clk <= 1'b1;
                        panel_out.pixels    <= pixels;
                    end
                end
                panel_ctrl_pkg::SHIFT: begin
                    panel_out.panel_clk <= 1'b0;
                    if (column < cfg.last_column) begin
                        column           <= column + 1'b1;
                        state            <= panel_ctrl_pkg::FETCH;
                        pixel_load_start <= 1'b1;
                    end else begin
                        // row done, blank while latching it
                        state           <= panel_ctrl_pkg::LATCH;
                        panel_out.latch <= 1'b1;
                        panel_out.blank <= 1'b1;
                        panel_out.row   <= row;
                    end
                end
                panel_ctrl_pkg::LATCH: begin
                    panel_out.latch <= 1'b0;
                    column          <= '0;
                    row             <= last_row ? '0 : row + 1'b1;
                    frame_done      <= last_row;
                    if (last_row && !cfg.run) begin
                        // stay blanked
                        state <= panel_ctrl_pkg::IDLE;
                    end else begin
                        state            <= panel_ctrl_pkg::FETCH;
                        pixel_load_start <= 1'b1;
                        panel_out.blank  <= 1'b0;
                    end
                end
                default: begin
                    state <= panel_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/led_panel_top.sv
/* pixel path of a small HUB75-style driver, no PWM planes and no handshakes
   host writes to RAM and config are single-cycle strobes */
`default_nettype none
`timescale 1ns/1ps

module led_panel_top (
    input  wire logic                            reset,
    input  wire logic                            clk_in,
    input  wire logic                            fb_write,
    input  wire panel_geometry_pkg::ram_addr_t   fb_addr,
    input  wire panel_geometry_pkg::pixel_pair_t fb_wdata,
    input  wire logic                            cfg_write,
    input  wire panel_ctrl_pkg::cfg_reg_e        cfg_sel,
    input  wire logic [2:0]                      cfg_wdata,
    output panel_ctrl_pkg::panel_out_t           panel_out,
    output logic                                 frame_done
);

    // fetch <-> RAM
    panel_geometry_pkg::ram_addr_t    ram_address;
    panel_geometry_pkg::pixel_pair_t  ram_rdata;
    logic                             ram_clk_enable;
    // scan <-> fetch
    panel_geometry_pkg::column_addr_t column;
    panel_geometry_pkg::row_addr_t    row;
    logic                             pixel_load_start;
    panel_geometry_pkg::pixel_pair_t  fetch_pixels;
    panel_ctrl_pkg::panel_cfg_t       cfg;

    framebuffer_ram fb_ram (
        .reset(reset), .clk_in(clk_in),
        .write(fb_write), .waddr(fb_addr), .wdata(fb_wdata),
        .read_enable(ram_clk_enable), .raddr(ram_address), .rdata(ram_rdata)
    );

    framebuffer_fetch fb_fetch (
        .reset(reset), .clk_in(clk_in),
        .column(column), .row(row), .pixel_load_start(pixel_load_start),
        .ram_rdata(ram_rdata), .ram_address(ram_address),
        .ram_clk_enable(ram_clk_enable), .pixels(fetch_pixels)
    );

    panel_config_regs cfg_regs (
        .reset(reset), .clk_in(clk_in),
        .cfg_write(cfg_write), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata), .cfg(cfg)
    );

    panel_scan scan (
        .reset(reset), .clk_in(clk_in),
        .cfg(cfg), .ram_clk_enable(ram_clk_enable), .pixels(fetch_pixels),
        .column(column), .row(row), .pixel_load_start(pixel_load_start),
        .panel_out(panel_out), .frame_done(frame_done)
    );

endmodule

`default_nettype wire

//--- tb/led_panel_checker.sv
/* panel and fetch timing rules, bound into every led_panel_top
   all rules are off while reset is high */
`default_nettype none
`timescale 1ns/1ps

`include "led_panel_defines.svh"

module led_panel_checker (
    input wire logic                       clk_in,
    input wire logic                       reset,
    input wire panel_ctrl_pkg::panel_out_t panel_out,
    input wire logic                       ram_clk_enable
);

    // shift and latch never overlap
    no_clk_during_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        !(panel_out.panel_clk && panel_out.latch)
    ) else $error("panel_clk and latch high in the same cycle");

    // latching only while the panel is dark
    latch_blanked: assert property (
        @(posedge clk_in) disable iff (reset)
        panel_out.latch |-> panel_out.blank
    ) else $error("latch high while blank is low");

    // read enable drops again within FETCH_WAIT cycles
    fetch_window: assert property (
        @(posedge clk_in) disable iff (reset)
        $rose(ram_clk_enable) |-> ##[1:`FETCH_WAIT] !ram_clk_enable
    ) else $error("ram_clk_enable high longer than the fetch wait");

endmodule

bind led_panel_top led_panel_checker checker_i (
    .clk_in(clk_in), .reset(reset), .panel_out(panel_out), .ram_clk_enable(ram_clk_enable)
);

`default_nettype wire

//--- tb/led_panel_tb.sv
/* testbench for led_panel_top, data from tb/led_panel_testdata.txt, run from the project root
   last_column and run are only changed where the scan reads them safely */
`default_nettype none
`timescale 1ns/1ps

`include "led_panel_defines.svh"

module led_panel_tb;

    localparam int num_words = `PANEL_COLUMNS * `PANEL_HALF_ROWS;
    // reset, 32 two-cycle writes and three frames of about 200 cycles, with margin
    localparam int max_cycles = 2000;

    logic                            clk_in;
    logic                            reset;
    logic                            fb_write;
    panel_geometry_pkg::ram_addr_t   fb_addr;
    panel_geometry_pkg::pixel_pair_t fb_wdata;
    logic                            cfg_write;
    panel_ctrl_pkg::cfg_reg_e        cfg_sel;
    logic [2:0]                      cfg_wdata;
    panel_ctrl_pkg::panel_out_t      panel_out;
    logic                            frame_done;

    // entry 0 is the later last column, then the pixel words
    logic [15:0] testdata [num_words+1];

    int errors;
    int cycles;
    int frames;
    int latches;
    int pulses;
    int row_pulses;
    int enable_run;
    // scan model
    int exp_row;
    int exp_col;
    int exp_last;
    logic scan_on;
    logic run_cleared;
    logic stopped;
    logic frame_pending;

    led_panel_top dut_i (
        .reset(reset), .clk_in(clk_in),
        .fb_write(fb_write), .fb_addr(fb_addr), .fb_wdata(fb_wdata),
        .cfg_write(cfg_write), .cfg_sel(cfg_sel), .cfg_wdata(cfg_wdata),
        .panel_out(panel_out), .frame_done(frame_done)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    task automatic write_word(input int addr, input logic [15:0] data);
        @(posedge clk_in);
        fb_write <= 1'b1;
        fb_addr  <= panel_geometry_pkg::ram_addr_t'(addr);
        fb_wdata <= data;
        @(posedge clk_in);
        fb_write <= 1'b0;
    endtask

    task automatic write_config(input panel_ctrl_pkg::cfg_reg_e sel, input logic [2:0] value);
        @(posedge clk_in);
        cfg_write <= 1'b1;
        cfg_sel   <= sel;
        cfg_wdata <= value;
        @(posedge clk_in);
        cfg_write <= 1'b0;
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk_in) begin
        if (!reset) begin
            if (dut_i.ram_clk_enable) enable_run++;
            else enable_run = 0;
            if (enable_run > `FETCH_WAIT) begin
                errors++;
                $display("%0t: ram_clk_enable stayed high past the fetch wait", $time);
            end
            if (panel_out.panel_clk && panel_out.latch) begin
                errors++;
                $display("%0t: panel_clk and latch high together", $time);
            end
            if (panel_out.latch && !panel_out.blank) begin
                errors++;
                $display("%0t: latch pulse without blank", $time);
            end
            // idle before run, and again once stopped
            if (!scan_on || stopped) begin
                if (panel_out.panel_clk || panel_out.latch || frame_done || !panel_out.blank) begin
                    errors++;
                    $display("%0t: panel activity while the scan should be idle", $time);
                end
            end
            if (panel_out.panel_clk) begin
                pulses++;
                row_pulses++;
                if (exp_col > exp_last) begin
                    errors++;
                    $display("%0t: panel clock beyond last column %0d", $time, exp_last);
                end else if (panel_out.pixels != testdata[1 + exp_row*`PANEL_COLUMNS + exp_col]) begin
                    errors++;
                    $display("mismatch at %0t: panel_out.pixels expected %h got %h", $time,
                             testdata[1 + exp_row*`PANEL_COLUMNS + exp_col], panel_out.pixels);
                end
                exp_col++;
            end
            if (panel_out.latch) begin
                latches++;
                if (panel_out.row != exp_row[1:0]) begin
                    errors++;
                    $display("mismatch at %0t: panel_out.row expected %0d got %0d", $time,
                             exp_row, panel_out.row);
                end
                if (row_pulses != exp_last + 1) begin
                    errors++;
                    $display("mismatch at %0t: panel clocks per row expected %0d got %0d",
                             $time, exp_last + 1, row_pulses);
                end
                row_pulses = 0;
                exp_col = 0;
                exp_row = (exp_row + 1) % `PANEL_HALF_ROWS;
                frame_pending = (exp_row == 0);
            end
            if (frame_done) begin
                if (!frame_pending) begin
                    errors++;
                    $display("%0t: frame_done before the last row was latched", $time);
                end
                frames++;
                frame_pending = 1'b0;
                // frame in progress has ended, nothing may follow
                if (run_cleared) stopped = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk_in);
            cycles++;
        end
        $display("timeout: scan did not finish within %0d cycles", max_cycles);
        $display("done: %0d errors, %0d panel clocks, %0d frames", errors, pulses, frames);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        fb_write      = 1'b0;
        fb_addr       = '0;
        fb_wdata      = '0;
        cfg_write     = 1'b0;
        cfg_sel       = panel_ctrl_pkg::CFG_RUN;
        cfg_wdata     = '0;
        errors        = 0;
        frames        = 0;
        latches       = 0;
        pulses        = 0;
        row_pulses    = 0;
        enable_run    = 0;
        exp_row       = 0;
        exp_col       = 0;
        exp_last      = `PANEL_COLUMNS - 1;
        scan_on       = 1'b0;
        run_cleared   = 1'b0;
        stopped       = 1'b0;
        frame_pending = 1'b0;
        $readmemh("tb/led_panel_testdata.txt", testdata);
        repeat (8) @(posedge clk_in);
        reset <= 1'b0;
        for (int i = 0; i < num_words; i++) begin
            write_word(i, testdata[i + 1]);
        end
        // idle outputs watched a little longer
        repeat (10) @(posedge clk_in);
        scan_on = 1'b1;
        write_config(panel_ctrl_pkg::CFG_RUN, 3'd1);
        while (frames < 1) @(posedge clk_in);
        // next frame is still fetching column 0
        exp_last = int'(testdata[0][2:0]);
        write_config(panel_ctrl_pkg::CFG_LAST_COL, testdata[0][2:0]);
        while (frames < 2) @(posedge clk_in);
        // stop request during the third frame
        while (latches < 2*`PANEL_HALF_ROWS + 1) @(posedge clk_in);
        run_cleared = 1'b1;
        write_config(panel_ctrl_pkg::CFG_RUN, 3'd0);
        while (frames < 3) @(posedge clk_in);
        repeat (100) @(posedge clk_in);
        if (pulses != num_words + 2*`PANEL_HALF_ROWS*(exp_last + 1)) begin
            errors++;
            $display("mismatch at %0t: total panel clocks expected %0d got %0d", $time,
                     num_words + 2*`PANEL_HALF_ROWS*(exp_last + 1), pulses);
        end
        $display("done: %0d errors, %0d panel clocks, %0d frames", errors, pulses, frames);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/led_panel_testdata.txt
// first value: last column for frames 2 and 3, low 3 bits used
// then 32 pixel words {bottom, top}, address = row * 8 + column
0004
// row 0
1a2b 3c4d 5e6f 7081 92a3 b4c5 d6e7 f809
// row 1
0b1c 2d3e 4f50 6172 8394 a5b6 c7d8 e9fa
// row 2
a01f b12e c23d d34c e45b f56a 0679 1788
// row 3
55aa 66bb 77cc 88dd 99ee aaff bb00 cc11

//--- led_panel_top.f
+incdir+logic
logic/panel_geometry_pkg.sv
logic/panel_ctrl_pkg.sv
logic/timeout.sv
logic/framebuffer_ram.sv
logic/framebuffer_fetch.sv
logic/panel_config_regs.sv
logic/panel_scan.sv
logic/led_panel_top.sv
tb/led_panel_checker.sv
tb/led_panel_tb.sv

//--- Bender.yml
package:
  name: led_panel

sources:
  - include_dirs:
      - logic
    files:
      - logic/panel_geometry_pkg.sv
      - logic/panel_ctrl_pkg.sv
      - logic/timeout.sv
      - logic/framebuffer_ram.sv
      - logic/framebuffer_fetch.sv
      - logic/panel_config_regs.sv
      - logic/panel_scan.sv
      - logic/led_panel_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - tb/led_panel_checker.sv
      - tb/led_panel_tb.sv
